// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // datapath and address width
    parameter int XLEN = 32;
    parameter int REG_ADDR_W = 5;

    // pass-b forwards operand b untouched for lui
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_BEQ  = 2'd1,
        BR_BNE  = 2'd2
    } branch_e;

    // fetch to decode
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_pkt_t;

    // decode to execute with operands already forwarded
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       branch_off;
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        branch_e               branch;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
    } exec_pkt_t;

    // execute to memory where the result doubles as the ram address
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        mem_op_e               mem_op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
    } mem_pkt_t;

    // register write that also feeds the bypass paths
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_pkt_t;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         hold_i,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic [rv_core_pkg::XLEN-1:0] redirect_pc_i,
    input  logic [rv_core_pkg::XLEN-1:0] rom_data_i,
    output logic                         rom_ce_o,
    output logic [rv_core_pkg::XLEN-1:0] rom_addr_o,
    output rv_core_pkg::fetch_pkt_t      fetch_o
);

    logic [rv_core_pkg::XLEN-1:0] pc_q;
    // stays low for the first cycle after reset
    logic                         fetch_en_q;

    assign rom_addr_o = pc_q;
    assign rom_ce_o   = fetch_en_q && !hold_i && !stall_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q          <= RESET_PC;
            fetch_en_q    <= 1'b0;
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
            if (!hold_i) begin
                if (redirect_i) begin
                    // squash the word fetched down the wrong path
                    pc_q          <= redirect_pc_i;
                    fetch_o.valid <= 1'b0;
                end else if (!stall_i) begin
                    if (fetch_en_q) begin
                        pc_q <= pc_q + 32'd4;
                    end
                    fetch_o.valid <= fetch_en_q;
                    fetch_o.pc    <= pc_q;
                    fetch_o.instr <= rom_data_i;
                end
            end
        end
    end

    // branch targets from execute must keep the pc on a word boundary
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        pc_q[1:0] == 2'b00
    ) else $error("fetch pc not word aligned");

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                               clk_i,
    input  rv_core_pkg::wb_pkt_t               wb_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data_o
);

    // only x1..x31 since x0 is hardwired
    logic [rv_core_pkg::XLEN-1:0] regs [31:1];

    always_ff @(posedge clk_i) begin
        if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // same-cycle writeback passes straight to the read port
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (wb_i.we && wb_i.rd == rs1_addr_i) ? wb_i.data : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (wb_i.we && wb_i.rd == rs2_addr_i) ? wb_i.data : regs[rs2_addr_i];

    // decode drops the write enable for rd = x0
    a_no_x0_write: assert property (
        @(posedge clk_i) wb_i.we |-> (wb_i.rd != '0)
    ) else $error("write to x0 reached the register file");

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               hold_i,
    input  logic                               flush_i,
    input  rv_core_pkg::fetch_pkt_t            fetch_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rs2_data_i,
    input  rv_core_pkg::wb_pkt_t               ex_fwd_i,
    input  logic                               ex_is_load_i,
    input  rv_core_pkg::wb_pkt_t               mem_fwd_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                               stall_o,
    output rv_core_pkg::exec_pkt_t             exec_o
);

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    logic [rv_core_pkg::XLEN-1:0] instr;
    opcode_e                      opcode;
    logic [2:0]                   funct3;
    logic [rv_core_pkg::XLEN-1:0] imm_i;
    logic [rv_core_pkg::XLEN-1:0] imm_s;
    logic [rv_core_pkg::XLEN-1:0] imm_b;
    logic [rv_core_pkg::XLEN-1:0] imm_u;
    logic [rv_core_pkg::XLEN-1:0] imm;
    logic [rv_core_pkg::XLEN-1:0] rs1_val;
    logic [rv_core_pkg::XLEN-1:0] rs2_val;
    logic                         b_is_imm;
    logic                         use_rs1;
    logic                         use_rs2;
    logic                         wr_en;
    rv_core_pkg::alu_op_e         alu_op;
    rv_core_pkg::mem_op_e         mem_op;
    rv_core_pkg::branch_e         br_kind;
    rv_core_pkg::exec_pkt_t       exec_d;

    assign instr      = fetch_i.instr;
    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // anything not recognised falls through as a no-op
    always_comb begin
        alu_op   = rv_core_pkg::ALU_ADD;
        mem_op   = rv_core_pkg::MEM_NONE;
        br_kind  = rv_core_pkg::BR_NONE;
        imm      = imm_i;
        b_is_imm = 1'b0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        wr_en    = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wr_en   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = instr[30] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b100:  alu_op = rv_core_pkg::ALU_XOR;
                    3'b110:  alu_op = rv_core_pkg::ALU_OR;
                    3'b111:  alu_op = rv_core_pkg::ALU_AND;
                    default: wr_en = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1  = 1'b1;
                b_is_imm = 1'b1;
                wr_en    = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                alu_op   = rv_core_pkg::ALU_PASS_B;
                imm      = imm_u;
                b_is_imm = 1'b1;
                wr_en    = 1'b1;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    use_rs1  = 1'b1;
                    b_is_imm = 1'b1;
                    mem_op   = rv_core_pkg::MEM_LOAD;
                    wr_en    = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    use_rs1  = 1'b1;
                    use_rs2  = 1'b1;
                    imm      = imm_s;
                    b_is_imm = 1'b1;
                    mem_op   = rv_core_pkg::MEM_STORE;
                end
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct3 == 3'b000) begin
                    br_kind = rv_core_pkg::BR_BEQ;
                end else if (funct3 == 3'b001) begin
                    br_kind = rv_core_pkg::BR_BNE;
                end
            end
            default: ;
        endcase
    end

    // execute result wins over memory, then the register file
    assign rs1_val = (ex_fwd_i.we && ex_fwd_i.rd == rs1_addr_o)   ? ex_fwd_i.data :
                     (mem_fwd_i.we && mem_fwd_i.rd == rs1_addr_o) ? mem_fwd_i.data :
                     rs1_data_i;
    assign rs2_val = (ex_fwd_i.we && ex_fwd_i.rd == rs2_addr_o)   ? ex_fwd_i.data :
                     (mem_fwd_i.we && mem_fwd_i.rd == rs2_addr_o) ? mem_fwd_i.data :
                     rs2_data_i;

    // load result not ready yet so decode holds one cycle
    assign stall_o = fetch_i.valid && ex_is_load_i && ex_fwd_i.we &&
                     ((use_rs1 && ex_fwd_i.rd == rs1_addr_o) ||
                      (use_rs2 && ex_fwd_i.rd == rs2_addr_o));

    always_comb begin
        exec_d.valid      = fetch_i.valid && !flush_i && !stall_o;
        exec_d.pc         = fetch_i.pc;
        exec_d.op_a       = rs1_val;
        exec_d.op_b       = b_is_imm ? imm : rs2_val;
        exec_d.store_data = rs2_val;
        exec_d.branch_off = imm_b;
        exec_d.alu_op     = alu_op;
        exec_d.mem_op     = mem_op;
        exec_d.branch     = br_kind;
        exec_d.rd         = instr[11:7];
        exec_d.rd_we      = wr_en && (instr[11:7] != '0);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exec_o.valid <= 1'b0;
        end else if (!hold_i) begin
            exec_o <= exec_d;
        end
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         hold_i,
    input  rv_core_pkg::exec_pkt_t       exec_i,
    output rv_core_pkg::wb_pkt_t         ex_fwd_o,
    output logic                         ex_is_load_o,
    output logic                         redirect_o,
    output logic [rv_core_pkg::XLEN-1:0] redirect_pc_o,
    output rv_core_pkg::mem_pkt_t        mem_o
);

    logic [rv_core_pkg::XLEN-1:0] alu_res;
    logic                         operands_eq;
    logic                         taken;

    always_comb begin
        case (exec_i.alu_op)
            rv_core_pkg::ALU_ADD: alu_res = exec_i.op_a + exec_i.op_b;
            rv_core_pkg::ALU_SUB: alu_res = exec_i.op_a - exec_i.op_b;
            rv_core_pkg::ALU_AND: alu_res = exec_i.op_a & exec_i.op_b;
            rv_core_pkg::ALU_OR:  alu_res = exec_i.op_a | exec_i.op_b;
            rv_core_pkg::ALU_XOR: alu_res = exec_i.op_a ^ exec_i.op_b;
            // lui immediate
            default:              alu_res = exec_i.op_b;
        endcase
    end

    assign operands_eq = (exec_i.op_a == exec_i.op_b);
    assign taken = (exec_i.branch == rv_core_pkg::BR_BEQ && operands_eq) ||
                   (exec_i.branch == rv_core_pkg::BR_BNE && !operands_eq);

    assign redirect_o    = exec_i.valid && taken;
    assign redirect_pc_o = exec_i.pc + exec_i.branch_off;

    // bypass back to decode
    assign ex_fwd_o.we   = exec_i.valid && exec_i.rd_we;
    assign ex_fwd_o.rd   = exec_i.rd;
    assign ex_fwd_o.data = alu_res;
    assign ex_is_load_o  = exec_i.valid && (exec_i.mem_op == rv_core_pkg::MEM_LOAD);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_o.valid <= 1'b0;
        end else if (!hold_i) begin
            // a taken branch leaves a bubble behind
            mem_o.valid      <= exec_i.valid && !redirect_o;
            mem_o.result     <= alu_res;
            mem_o.store_data <= exec_i.store_data;
            mem_o.mem_op     <= exec_i.mem_op;
            mem_o.rd         <= exec_i.rd;
            mem_o.rd_we      <= exec_i.rd_we;
        end
    end

    // the instruction behind a taken branch must arrive flushed
    a_redirect_flush: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (redirect_o && !hold_i) |=> !exec_i.valid
    ) else $error("younger instruction survived a taken branch");

endmodule

`default_nettype wire

// ==== mem_access.sv ====
`default_nettype none

module mem_access (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  rv_core_pkg::mem_pkt_t        mem_i,
    input  logic                         ram_data_rvalid_i,
    input  logic [rv_core_pkg::XLEN-1:0] ram_data_i,
    output logic                         ram_ce_o,
    output logic                         ram_we_o,
    output logic [rv_core_pkg::XLEN-1:0] ram_addr_o,
    output logic [rv_core_pkg::XLEN-1:0] ram_data_o,
    output logic                         hold_o,
    output rv_core_pkg::wb_pkt_t         mem_fwd_o,
    output rv_core_pkg::wb_pkt_t         wb_o
);

    logic is_load;
    logic is_store;

    assign is_load  = mem_i.valid && (mem_i.mem_op == rv_core_pkg::MEM_LOAD);
    assign is_store = mem_i.valid && (mem_i.mem_op == rv_core_pkg::MEM_STORE);

    // request comes straight off the ex/mem register
    assign ram_ce_o   = is_load || is_store;
    assign ram_we_o   = is_store;
    assign ram_addr_o = mem_i.result;
    assign ram_data_o = mem_i.store_data;

    // freeze the whole pipe until the load reply shows up
    assign hold_o = is_load && !ram_data_rvalid_i;

    assign mem_fwd_o.we   = mem_i.valid && mem_i.rd_we;
    assign mem_fwd_o.rd   = mem_i.rd;
    assign mem_fwd_o.data = is_load ? ram_data_i : mem_i.result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o.we <= 1'b0;
        end else if (!hold_o) begin
            wb_o <= mem_fwd_o;
        end
    end

    // upstream registers must hold the request steady
    a_addr_stable: assert property (
        @(posedge clk_i) disable iff (reset_i)
        hold_o |=> ($stable(ram_addr_o) && ram_ce_o && !ram_we_o)
    ) else $error("ram request changed while waiting for load data");

endmodule

`default_nettype wire

// ==== core_top.sv ====
`default_nettype none

module core_top #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    // instruction rom
    output logic                         rom_ce_o,
    output logic [rv_core_pkg::XLEN-1:0] rom_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0] rom_data_i,
    // data ram
    output logic                         ram_ce_o,
    output logic                         ram_we_o,
    output logic [rv_core_pkg::XLEN-1:0] ram_addr_o,
    output logic [rv_core_pkg::XLEN-1:0] ram_data_o,
    input  logic                         ram_data_rvalid_i,
    input  logic [rv_core_pkg::XLEN-1:0] ram_data_i
);

    rv_core_pkg::fetch_pkt_t            fetch_pkt;
    rv_core_pkg::exec_pkt_t             exec_pkt;
    rv_core_pkg::mem_pkt_t              mem_pkt;
    rv_core_pkg::wb_pkt_t               wb_pkt;
    rv_core_pkg::wb_pkt_t               ex_fwd;
    rv_core_pkg::wb_pkt_t               mem_fwd;
    logic                               ex_is_load;
    logic                               hold;
    logic                               stall;
    logic                               redirect;
    logic [rv_core_pkg::XLEN-1:0]       redirect_pc;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_core_pkg::XLEN-1:0]       rs1_data;
    logic [rv_core_pkg::XLEN-1:0]       rs2_data;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk_i(clk_i), .reset_i(reset_i), .hold_i(hold), .stall_i(stall),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc), .rom_data_i(rom_data_i),
        .rom_ce_o(rom_ce_o), .rom_addr_o(rom_addr_o), .fetch_o(fetch_pkt)
    );

    decode_stage u_decode (
        .clk_i(clk_i), .reset_i(reset_i), .hold_i(hold), .flush_i(redirect),
        .fetch_i(fetch_pkt), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_fwd_i(ex_fwd), .ex_is_load_i(ex_is_load), .mem_fwd_i(mem_fwd),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .stall_o(stall), .exec_o(exec_pkt)
    );

    reg_file u_regs (
        .clk_i(clk_i), .wb_i(wb_pkt), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    execute_stage u_execute (
        .clk_i(clk_i), .reset_i(reset_i), .hold_i(hold), .exec_i(exec_pkt),
        .ex_fwd_o(ex_fwd), .ex_is_load_o(ex_is_load), .redirect_o(redirect),
        .redirect_pc_o(redirect_pc), .mem_o(mem_pkt)
    );

    mem_access u_mem (
        .clk_i(clk_i), .reset_i(reset_i), .mem_i(mem_pkt),
        .ram_data_rvalid_i(ram_data_rvalid_i), .ram_data_i(ram_data_i),
        .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o), .ram_addr_o(ram_addr_o),
        .ram_data_o(ram_data_o), .hold_o(hold), .mem_fwd_o(mem_fwd), .wb_o(wb_pkt)
    );

endmodule

`default_nettype wire

// ==== tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// one row per program with four instruction words per line and nop padding
localparam int NUM_PROGS  = 5;
localparam int MAX_WORDS  = 16;
localparam int MAX_STORES = 6;

localparam logic [31:0] PROG_WORDS [NUM_PROGS][MAX_WORDS] = '{
    // alu ops, back to back so execute and memory bypasses are used
    '{32'h00500093, 32'h00E00113, 32'h002081B3, 32'h40118233,
      32'h0021F2B3, 32'h0050E333, 32'h003343B3, 32'hFFD38393,
      32'h10702823, 32'h10302023, 32'h10402223, 32'h10502423,
      32'h10602623, 32'h00000063, 32'h00000013, 32'h00000013},
    // lui + addi constants, addi to x0 then store x0
    '{32'h123450B7, 32'h67808093, 32'hDEADC137, 32'hEEF10113,
      32'h06300013, 32'h10002423, 32'h10102023, 32'h10202223,
      32'h00000063, 32'h00000013, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    // load followed at once by its consumer
    '{32'h12300113, 32'h04002083, 32'h002081B3, 32'h10302023,
      32'h04402203, 32'h10402223, 32'h10002283, 32'h00528333,
      32'h10602423, 32'h00000063, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    // bne not taken, beq taken, beq not taken, bne taken
    '{32'h00700093, 32'h00700113, 32'h00209663, 32'h10102023,
      32'h00208663, 32'h10102223, 32'h10202423, 32'h00900193,
      32'h00118463, 32'h10302623, 32'h00119663, 32'h10302823,
      32'h10302A23, 32'h10202C23, 32'h00000063, 32'h00000013},
    // stores mixed with back to back loads
    '{32'h00100093, 32'h10102023, 32'h08002103, 32'h10202223,
      32'h08402183, 32'h08802203, 32'h10102423, 32'h403202B3,
      32'h10502623, 32'h10302823, 32'h10402303, 32'h10602A23,
      32'h00000063, 32'h00000013, 32'h00000013, 32'h00000013}
};

// expected stores as {address, data} in program order with unused slots zero
localparam logic [63:0] EXP_STORES [NUM_PROGS][MAX_STORES] = '{
    '{64'h00000110_00000011, 64'h00000100_00000013, 64'h00000104_0000000E,
      64'h00000108_00000002, 64'h0000010C_00000007, 64'h0},
    '{64'h00000108_00000000, 64'h00000100_12345678, 64'h00000104_DEADBEEF,
      64'h0, 64'h0, 64'h0},
    '{64'h00000100_C0DE0163, 64'h00000104_C0DE0044, 64'h00000108_81BC02C6,
      64'h0, 64'h0, 64'h0},
    '{64'h00000100_00000007, 64'h0000010C_00000009, 64'h00000118_00000007,
      64'h0, 64'h0, 64'h0},
    '{64'h00000100_00000001, 64'h00000104_C0DE0080, 64'h00000108_00000001,
      64'h0000010C_00000004, 64'h00000110_C0DE0084, 64'h00000114_C0DE0080}
};

localparam int EXP_COUNT [NUM_PROGS] = '{5, 3, 3, 3, 6};

`endif

// ==== tb_core_top.sv ====
`default_nettype none

module tb_core_top;
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_programs.svh"

    localparam int RAM_WORDS     = 256;
    localparam int STORE_TIMEOUT = 500;
    localparam int QUIET_CYCLES  = 20;

    logic        clk_i;
    logic        reset_i;
    logic        rom_ce_o;
    logic [31:0] rom_addr_o;
    logic [31:0] rom_data_i;
    logic        ram_ce_o;
    logic        ram_we_o;
    logic [31:0] ram_addr_o;
    logic [31:0] ram_data_o;
    logic        ram_data_rvalid_i;
    logic [31:0] ram_data_i;

    logic [31:0] rom_mem [MAX_WORDS];
    logic [31:0] ram_mem [RAM_WORDS];

    int   value_errors;
    int   other_failures;
    int   prog_idx;
    int   stores_seen;
    logic load_busy;
    int   load_wait;

    core_top #(.RESET_PC(32'h0000_0000)) core_top_inst (
        .clk_i(clk_i), .reset_i(reset_i),
        .rom_ce_o(rom_ce_o), .rom_addr_o(rom_addr_o), .rom_data_i(rom_data_i),
        .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o), .ram_addr_o(ram_addr_o),
        .ram_data_o(ram_data_o), .ram_data_rvalid_i(ram_data_rvalid_i),
        .ram_data_i(ram_data_i)
    );

    always #4 clk_i = ~clk_i;

    // rom answers in the same cycle while enabled
    assign rom_data_i = rom_ce_o ? rom_mem[rom_addr_o[5:2]] : 32'h0000_0000;

    task automatic load_program(input int p);
        for (int w = 0; w < MAX_WORDS; w++) begin
            rom_mem[w] = PROG_WORDS[p][w];
        end
    endtask

    // every word holds a marker plus its own byte address
    task automatic preset_ram();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_mem[i] = 32'hC0DE0000 | 32'(i * 4);
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [63:0] expected;
        if (stores_seen >= EXP_COUNT[prog_idx]) begin
            other_failures++;
            $display("program %0d made an extra store at time %0t, addr %h data %h",
                     prog_idx, $time, addr, data);
        end else begin
            expected = EXP_STORES[prog_idx][stores_seen];
            if (addr != expected[63:32] || data != expected[31:0]) begin
                value_errors++;
                $display("ERR %0t: program %0d store %0d got %h <= %h, expected %h <= %h",
                         $time, prog_idx, stores_seen, addr, data,
                         expected[63:32], expected[31:0]);
            end
        end
        stores_seen++;
    endtask

    // ram model samples mid cycle while the request is stable
    always @(negedge clk_i) begin
        if (reset_i) begin
            if (ram_ce_o && ram_we_o) begin
                other_failures++;
                $display("a RAM write appeared while reset was asserted, time %0t", $time);
            end
            if (rom_ce_o) begin
                other_failures++;
                $display("the ROM enable was high while reset was asserted, time %0t", $time);
            end
            ram_data_rvalid_i <= 1'b0;
            load_busy = 1'b0;
        end else if (ram_ce_o && ram_we_o) begin
            ram_data_rvalid_i <= 1'b0;
            check_store(ram_addr_o, ram_data_o);
            ram_mem[ram_addr_o[9:2]] = ram_data_o;
        end else if (ram_ce_o) begin
            // new load request picks its own latency of 0 to 3 cycles
            if (!load_busy) begin
                load_wait = $urandom % 4;
                load_busy = 1'b1;
            end
            if (load_wait == 0) begin
                ram_data_rvalid_i <= 1'b1;
                ram_data_i        <= ram_mem[ram_addr_o[9:2]];
                load_busy = 1'b0;
            end else begin
                ram_data_rvalid_i <= 1'b0;
                load_wait--;
            end
        end else begin
            ram_data_rvalid_i <= 1'b0;
        end
    end

    task automatic run_program(input int p);
        int cycles;
        @(negedge clk_i);
        reset_i <= 1'b1;
        // core is in reset from here so the memories can be swapped
        @(negedge clk_i);
        load_program(p);
        preset_ram();
        prog_idx    = p;
        stores_seen = 0;
        @(negedge clk_i);
        reset_i <= 1'b0;
        cycles = 0;
        while (stores_seen < EXP_COUNT[p] && cycles < STORE_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (stores_seen < EXP_COUNT[p]) begin
            other_failures++;
            $display("timeout: program %0d made only %0d of %0d expected stores",
                     p, stores_seen, EXP_COUNT[p]);
        end
        // any late store is caught by the ram model
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
    endtask

    initial begin
        int seed_ret;
        clk_i             = 1'b0;
        reset_i           = 1'b1;
        ram_data_rvalid_i = 1'b0;
        ram_data_i        = '0;
        value_errors      = 0;
        other_failures    = 0;
        prog_idx          = 0;
        stores_seen       = 0;
        load_busy         = 1'b0;
        load_wait         = 0;
        seed_ret = $urandom(32'h97bf);
        load_program(0);
        preset_ram();

        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end

        $display("tb_core_top: %0d value errors, %0d other failures",
                 value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
rv_core_pkg.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_access.sv
core_top.sv
tb_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_core_top -f project.f -o tb_core_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_core_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi
